// ==== rtl/mul8_consts.svh ====
`ifndef MUL8_CONSTS_SVH
`define MUL8_CONSTS_SVH

`define MUL8_OP_W    8
`define MUL8_PROD_W  16
`define MUL8_ROW_W   14
`define MUL8_LATENCY 3

`endif

// ==== rtl/mul8_pkg.sv ====
`include "mul8_consts.svh"

package mul8_pkg;

    // one multiplier operand
    typedef logic [`MUL8_OP_W-1:0] operand_t;

    // full unsigned product
    typedef logic [`MUL8_PROD_W-1:0] product_t;

    // one of the two rows that enter the final add, weights 1 to 14
    typedef logic [`MUL8_ROW_W-1:0] row_t;

endpackage

// ==== rtl/cla_adder.sv ====
`timescale 1ns/1ps

module cla_adder #(
    parameter int WIDTH = 8
) (
    output logic [WIDTH-1:0] sum,
    output logic             cout,
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y
);

    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] p;
    logic [WIDTH:0]   c;

    assign g = x & y;
    assign p = x ^ y;

    // there is no carry in
    assign c[0] = 1'b0;

    // each carry is the OR of every generate term that can reach it
    // through an unbroken run of propagates, so no carry ripples
    for (genvar i = 0; i < WIDTH; i++) begin : g_carry
        logic [i:0] terms;

        for (genvar j = 0; j <= i; j++) begin : g_term
            if (j == i) begin : g_direct
                assign terms[j] = g[j];
            end else begin : g_chain
                assign terms[j] = g[j] & (&p[i:j+1]);
            end
        end

        assign c[i+1] = |terms;
    end

    assign sum  = p ^ c[WIDTH-1:0];
    assign cout = c[WIDTH];

endmodule

// ==== rtl/operand_capture.sv ====
`timescale 1ns/1ps

module operand_capture (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  mul8_pkg::operand_t a,
    input  mul8_pkg::operand_t b,
    output logic               cap_valid,
    output mul8_pkg::operand_t cap_a,
    output mul8_pkg::operand_t cap_b
);

    import mul8_pkg::*;

    // the strobe follows in_valid every cycle, the operands only move
    // when a new pair is offered
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cap_valid <= 1'b0;
            cap_a     <= '0;
            cap_b     <= '0;
        end else begin
            cap_valid <= in_valid;
            if (in_valid) begin
                cap_a <= a;
                cap_b <= b;
            end
        end
    end

endmodule

// ==== rtl/pp_reduction.sv ====
`timescale 1ns/1ps
`include "mul8_consts.svh"

module pp_reduction (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cap_valid,
    input  mul8_pkg::operand_t cap_a,
    input  mul8_pkg::operand_t cap_b,
    output logic               red_valid,
    output mul8_pkg::row_t     row_x,
    output mul8_pkg::row_t     row_y,
    output logic               bit0
);

    import mul8_pkg::*;

    // ############################################################
    // partial products
    // ############################################################

    // pp[i][j] carries weight i+j
    operand_t pp [`MUL8_OP_W];

    for (genvar i = 0; i < `MUL8_OP_W; i++) begin : g_pp
        assign pp[i] = cap_a[i] ? cap_b : '0;
    end

    // ############################################################
    // stage 1
    // ############################################################

    // every operand vector below is written msb first, so bit 0 holds
    // the lowest weight of its column group

    // weights 4 to 11
    logic [7:0] s1, in1_1, in1_2;
    logic       c1;
    assign in1_1 = {pp[4][7], pp[3][7], pp[2][7], pp[1][7],
                    pp[0][7], pp[0][6], pp[0][5], pp[0][4]};
    assign in1_2 = {pp[5][6], pp[4][6], pp[3][6], pp[2][6],
                    pp[1][6], pp[1][5], pp[1][4], pp[1][3]};
    cla_adder #(.WIDTH(8)) u_cla1 (.sum(s1), .cout(c1), .x(in1_1), .y(in1_2));

    // weights 5 to 10
    logic [5:0] s2, in2_1, in2_2;
    logic       c2;
    assign in2_1 = {pp[5][5], pp[4][5], pp[3][5], pp[2][5], pp[2][4], pp[2][3]};
    assign in2_2 = {pp[6][4], pp[5][4], pp[4][4], pp[3][4], pp[3][3], pp[3][2]};
    cla_adder #(.WIDTH(6)) u_cla2 (.sum(s2), .cout(c2), .x(in2_1), .y(in2_2));

    // weights 6 to 9
    logic [3:0] s3, in3_1, in3_2;
    logic       c3;
    assign in3_1 = {pp[6][3], pp[5][3], pp[4][3], pp[4][2]};
    assign in3_2 = {pp[7][2], pp[6][2], pp[5][2], pp[5][1]};
    cla_adder #(.WIDTH(4)) u_cla3 (.sum(s3), .cout(c3), .x(in3_1), .y(in3_2));

    // weights 7 and 8
    logic [1:0] s4, in4_1, in4_2;
    logic       c4;
    assign in4_1 = {pp[7][1], pp[6][1]};
    assign in4_2 = {1'b0, pp[7][0]};
    cla_adder #(.WIDTH(2)) u_cla4 (.sum(s4), .cout(c4), .x(in4_1), .y(in4_2));

    // ############################################################
    // stage 2
    // ############################################################

    // weights 2 to 13
    logic [11:0] s5, in5_1, in5_2;
    logic        c5;
    assign in5_1 = {pp[6][7], pp[5][7], pp[6][5], pp[7][3], s1[5], s1[4],
                    s1[3], pp[6][0], pp[4][1], pp[2][2], pp[0][3], pp[0][2]};
    assign in5_2 = {pp[7][6], pp[6][6], pp[7][4], s1[6], s2[4], s2[3],
                    s2[2], s1[2], pp[5][0], pp[3][1], pp[1][2], pp[1][1]};
    cla_adder #(.WIDTH(12)) u_cla5 (.sum(s5), .cout(c5), .x(in5_1), .y(in5_2));

    // weights 3 to 12, which also folds in the middle of s5
    logic [9:0] s6, in6_1, in6_2;
    logic       c6;
    assign in6_1 = {pp[7][5], s1[7], s2[5], s3[3], s3[2],
                    s3[1], s2[1], s1[1], pp[4][0], pp[2][1]};
    assign in6_2 = {s5[10], s5[9], s5[8], s5[7], s4[1],
                    s4[0], s3[0], s2[0], s1[0], pp[3][0]};
    cla_adder #(.WIDTH(10)) u_cla6 (.sum(s6), .cout(c6), .x(in6_1), .y(in6_2));

    // ############################################################
    // rows for the final add, weights 1 to 14
    // ############################################################

    row_t row_x_d;
    row_t row_y_d;

    assign row_x_d = {pp[7][7], s5[11], c1, c2, c3, c4, s5[6], s5[5],
                      s5[4], s5[3], s5[2], s5[1], pp[2][0], pp[0][1]};
    assign row_y_d = {c5, c6, s6[9], s6[8], s6[7], s6[6], s6[5], s6[4],
                      s6[3], s6[2], s6[1], s6[0], s5[0], pp[1][0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            red_valid <= 1'b0;
            row_x     <= '0;
            row_y     <= '0;
            bit0      <= 1'b0;
        end else begin
            red_valid <= cap_valid;
            if (cap_valid) begin
                row_x <= row_x_d;
                row_y <= row_y_d;
                bit0  <= pp[0][0];
            end
        end
    end

endmodule

// ==== rtl/product_output.sv ====
`timescale 1ns/1ps
`include "mul8_consts.svh"

module product_output (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               red_valid,
    input  mul8_pkg::row_t     row_x,
    input  mul8_pkg::row_t     row_y,
    input  logic               bit0,
    output logic               out_valid,
    output mul8_pkg::product_t product
);

    import mul8_pkg::*;

    row_t     sum;
    logic     cout;
    product_t product_d;

    cla_adder #(.WIDTH(`MUL8_ROW_W)) u_cla_final (
        .sum  (sum),
        .cout (cout),
        .x    (row_x),
        .y    (row_y)
    );

    // the rows start at weight 1, bit 0 bypasses the adder entirely
    assign product_d = {cout, sum, bit0};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= red_valid;
            if (red_valid) begin
                product <= product_d;
            end
        end
    end

endmodule

// ==== rtl/mul8_unit.sv ====
`timescale 1ns/1ps

module mul8_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  mul8_pkg::operand_t a,
    input  mul8_pkg::operand_t b,
    output logic               out_valid,
    output mul8_pkg::product_t product
);

    import mul8_pkg::*;

    logic     cap_valid;
    operand_t cap_a;
    operand_t cap_b;
    logic     red_valid;
    row_t     row_x;
    row_t     row_y;
    logic     bit0;

    operand_capture u_capture (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .cap_valid (cap_valid),
        .cap_a     (cap_a),
        .cap_b     (cap_b)
    );

    pp_reduction u_reduction (
        .clk       (clk),
        .arst_n    (arst_n),
        .cap_valid (cap_valid),
        .cap_a     (cap_a),
        .cap_b     (cap_b),
        .red_valid (red_valid),
        .row_x     (row_x),
        .row_y     (row_y),
        .bit0      (bit0)
    );

    product_output u_output (
        .clk       (clk),
        .arst_n    (arst_n),
        .red_valid (red_valid),
        .row_x     (row_x),
        .row_y     (row_y),
        .bit0      (bit0),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

// ==== tests/mul8_unit_properties.sv ====
`timescale 1ns/1ps
`include "mul8_consts.svh"

module mul8_unit_properties (
    input logic               clk,
    input logic               arst_n,
    input logic               in_valid,
    input mul8_pkg::operand_t a,
    input mul8_pkg::operand_t b,
    input logic               out_valid,
    input mul8_pkg::product_t product
);

    import mul8_pkg::*;

    localparam int LAT = `MUL8_LATENCY;

    logic [LAT-1:0] valid_hist;
    product_t       exp_hist [LAT];

    // shadow pipeline, cleared by the same reset as the DUT
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_hist <= '0;
            for (int i = 0; i < LAT; i++) begin
                exp_hist[i] <= '0;
            end
        end else begin
            valid_hist  <= {valid_hist[LAT-2:0], in_valid};
            exp_hist[0] <= product_t'(a) * product_t'(b);
            for (int i = 1; i < LAT; i++) begin
                exp_hist[i] <= exp_hist[i-1];
            end
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == valid_hist[LAT-1])
        else $error("out_valid does not follow in_valid by %0d cycles", LAT);

    a_product: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> product == exp_hist[LAT-1])
        else $error("product %0h differs from a*b %0h", product, exp_hist[LAT-1]);

    a_known: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(product))
        else $error("product has unknown bits while out_valid is high");

    a_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid is high during reset");

endmodule

bind mul8_unit mul8_unit_properties u_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
);

// ==== tests/mul8_unit_tb.sv ====
`timescale 1ns/1ps
`include "mul8_consts.svh"

module mul8_unit_tb;

    import mul8_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int N_CORNER      = 20;
    localparam int N_RANDOM      = 300;
    localparam int N_BURST       = 200;
    localparam int N_AFTER_RESET = 20;
    localparam int DRAIN_LIMIT   = 4 * `MUL8_LATENCY + 8;

    // random items take up to four cycles each, every test drains once more
    localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + N_CORNER + 4 * N_RANDOM + N_BURST
                                   + N_AFTER_RESET + 16 + 5 * DRAIN_LIMIT + 100;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    product_t ref_q [$];
    int       check_count;
    int       error_count;
    int       pulse_count;
    int       run_len;
    int       max_run;
    integer   seed;

    mul8_unit dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic operand_t random_operand();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic send_pair(input operand_t a_v, input operand_t b_v);
        @(negedge clk);
        in_valid = 1'b1;
        a        = a_v;
        b        = b_v;
        ref_q.push_back(product_t'(a_v) * product_t'(b_v));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (ref_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ref_q.size() != 0) begin
            error_count++;
            $display("ERROR at %0t: %0d expected products never came out", $time, ref_q.size());
            ref_q.delete();
        end
    endtask

    // outputs settle right after the rising edge
    always @(posedge clk) begin
        #1;
        if (out_valid === 1'b1) begin
            pulse_count++;
            run_len++;
            if (run_len > max_run) begin
                max_run = run_len;
            end
            if (ref_q.size() == 0) begin
                error_count++;
                $display("ERROR at %0t: out_valid pulse with no pair pending", $time);
            end else begin
                check_value("product", ref_q.pop_front(), product);
            end
        end else begin
            run_len = 0;
        end
    end

    // ############################################################
    // tests
    // ############################################################

    task automatic test_reset_state();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("out_valid", 16'd0, {15'd0, out_valid});
            check_value("product", 16'd0, product);
        end
        arst_n = 1'b1;
        idle_cycles(2);
        check_value("out_valid", 16'd0, {15'd0, out_valid});
        check_value("product", 16'd0, product);
    endtask

    task automatic test_corners();
        send_pair(8'd0, 8'd0);
        send_pair(8'd0, 8'd255);
        send_pair(8'd1, 8'd255);
        send_pair(8'd255, 8'd255);
        // single set bits on either side walk every partial-product row
        for (int k = 0; k < 8; k++) begin
            send_pair(8'd1 << k, 8'd255);
            send_pair(8'd255, 8'd1 << k);
        end
        idle_cycles(1);
        wait_drain();
    endtask

    task automatic test_random_single();
        int          pulses_before;
        logic [31:0] r;
        pulses_before = pulse_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_pair(random_operand(), random_operand());
            r = $random(seed);
            idle_cycles(int'(r[1:0]));
        end
        idle_cycles(1);
        wait_drain();
        check_value("out_valid pulses", 16'(pulses_before + N_RANDOM), 16'(pulse_count));
    endtask

    task automatic test_full_throughput();
        int pulses_before;
        pulses_before = pulse_count;
        max_run       = 0;
        for (int i = 0; i < N_BURST; i++) begin
            send_pair(random_operand(), random_operand());
        end
        idle_cycles(1);
        wait_drain();
        check_value("out_valid pulses", 16'(pulses_before + N_BURST), 16'(pulse_count));
        check_value("out_valid run length", 16'(N_BURST), 16'(max_run));
    endtask

    task automatic test_reset_midstream();
        int pulses_before;
        // back to back, so three pairs are still in the pipeline afterwards
        for (int i = 0; i < 5; i++) begin
            send_pair(random_operand(), random_operand());
        end
        @(negedge clk);
        arst_n   = 1'b0;
        in_valid = 1'b0;
        ref_q.delete();
        pulses_before = pulse_count;
        idle_cycles(2);
        check_value("out_valid", 16'd0, {15'd0, out_valid});
        arst_n = 1'b1;
        idle_cycles(8);
        check_value("out_valid pulses", 16'(pulses_before), 16'(pulse_count));
        for (int i = 0; i < N_AFTER_RESET; i++) begin
            send_pair(random_operand(), random_operand());
        end
        idle_cycles(1);
        wait_drain();
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        a           = '0;
        b           = '0;
        seed        = 76848;
        check_count = 0;
        error_count = 0;
        pulse_count = 0;
        run_len     = 0;
        max_run     = 0;

        test_reset_state();
        test_corners();
        test_random_single();
        test_full_throughput();
        test_reset_midstream();
        idle_cycles(4);

        if (ref_q.size() != 0) begin
            error_count++;
            $display("ERROR: %0d expected products left over at the end", ref_q.size());
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/mul8_pkg.sv
rtl/cla_adder.sv
rtl/operand_capture.sv
rtl/pp_reduction.sv
rtl/product_output.sv
rtl/mul8_unit.sv
tests/mul8_unit_properties.sv
tests/mul8_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module mul8_unit_tb -o mul8_unit_sim

output=$(./obj_dir/mul8_unit_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
